/* build.f */
design/dcache_pkg.sv
design/dpsram.sv
design/store_buffer.sv
design/load_align.sv
design/dcache.sv
testbench/tb_dcache.sv

/* design/dcache.sv */
`timescale 1ns/1ns

module dcache
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  logic                   stall_i,
    // request
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic [WORD_BITS-1:0]   req_addr_i,
    input  word_t                  req_wdata_i,
    input  logic [WORD_BYTES-1:0]  req_strb_i,
    input  logic [1:0]             req_msize_i,
    input  logic                   req_msigned_i,
    input  logic                   req_wreg_i,
    input  logic [REG_ID_BITS-1:0] req_wreg_id_i,
    // response
    input  logic                   resp_ready_i,
    output logic                   resp_valid_o,
    output word_t                  resp_rdata_o,
    output logic                   resp_hit_o,
    output logic [WAY_NUM-1:0]     resp_tag_hit_o,
    output logic                   resp_exc_o,
    output logic [5:0]             resp_ecode_o,
    output logic [WORD_BITS-1:0]   resp_badv_o,
    output logic [WAY_NUM-1:0]     resp_refill_way_o,
    output logic                   resp_dirty_o,
    output logic [WORD_BITS-1:0]   resp_dirty_addr_o,
    output logic [REG_ID_BITS-1:0] resp_wreg_id_o,
    // wakeup
    output logic                   wkup_valid_o,
    output logic [REG_ID_BITS-1:0] wkup_reg_id_o,
    // commit port
    input  logic [WORD_BITS-1:0]   commit_addr_i,
    input  logic [WAY_NUM-1:0]     commit_way_i,
    input  logic                   commit_tag_we_i,
    input  cache_tag_t             commit_tag_i,
    input  logic [WORD_BYTES-1:0]  commit_strb_i,
    input  word_t                  commit_wdata_i,
    input  logic                   commit_fetch_sb_i,
    output word_t                  commit_rdata_o,
    output word_t                  commit_rdata_other_o,
    output logic                   commit_miss_dirty_o,
    output logic                   commit_sb_valid_o,
    output logic [WORD_BITS-1:0]   commit_sb_addr_o,
    output word_t                  commit_sb_data_o,
    output logic [WORD_BYTES-1:0]  commit_sb_strb_o
);
    logic                   sb_full;
    logic                   m1_valid;
    logic                   m1_live;
    logic [WORD_BITS-1:0]   m1_addr;
    word_t                  m1_wdata;
    logic [WORD_BYTES-1:0]  m1_strb;
    logic [1:0]             m1_msize;
    logic                   m1_msigned;
    logic                   m1_wreg;
    logic [REG_ID_BITS-1:0] m1_wreg_id;
    logic [WAY_NUM-1:0]     commit_way_q;
    cache_tag_t             tag_m1 [WAY_NUM];
    cache_tag_t             tag_p1 [WAY_NUM];
    word_t                  data_m1 [WAY_NUM];
    word_t                  data_p1 [WAY_NUM];

    assign req_ready_o = resp_ready_i & !stall_i & !sb_full & !flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid     <= 1'b0;
            commit_way_q <= '0;
        end else begin
            m1_valid     <= req_valid_i & req_ready_o;
            commit_way_q <= commit_way_i;
        end
    end

    always_ff @(posedge clk) begin
        m1_addr    <= req_addr_i;
        m1_wdata   <= req_wdata_i;
        m1_strb    <= req_strb_i;
        m1_msize   <= req_msize_i;
        m1_msigned <= req_msigned_i;
        m1_wreg    <= req_wreg_i;
        m1_wreg_id <= req_wreg_id_i;
    end

    // a flush during M1 kills the item
    assign m1_live = m1_valid & !flush_i;

    assign wkup_valid_o  = m1_live & m1_wreg;
    assign wkup_reg_id_o = m1_wreg_id;

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        logic       tag_conflict;
        logic       tag_conflict_q;
        logic       data_conflict;
        logic       data_conflict_q;
        cache_tag_t rtag0;
        word_t      rdata0;

        // same index on both ports, so read through the commit side
        assign tag_conflict  = req_addr_i[TAG_LOW-1:INDEX_LOW] ==
                               commit_addr_i[TAG_LOW-1:INDEX_LOW];
        assign data_conflict = req_addr_i[TAG_LOW-1:WORD_LOW] ==
                               commit_addr_i[TAG_LOW-1:WORD_LOW];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tag_conflict_q  <= 1'b0;
                data_conflict_q <= 1'b0;
            end else begin
                tag_conflict_q  <= tag_conflict;
                data_conflict_q <= data_conflict;
            end
        end

        assign tag_m1[w]  = tag_conflict_q ? tag_p1[w] : rtag0;
        assign data_m1[w] = data_conflict_q ? data_p1[w] : rdata0;

        dpsram #(
            .ENTRY_T (cache_tag_t),
            .DEPTH   (SET_NUM),
            .LANES   (1)
        ) i_tag_ram (
            .clk      (clk),
            .rst_n    (rst_n),
            .addr0_i  (req_addr_i[TAG_LOW-1:INDEX_LOW]),
            .en0_i    (!tag_conflict),
            .rdata0_o (rtag0),
            .addr1_i  (commit_addr_i[TAG_LOW-1:INDEX_LOW]),
            .we1_i    (commit_way_i[w] & commit_tag_we_i),
            .wdata1_i (commit_tag_i),
            .rdata1_o (tag_p1[w])
        );

        dpsram #(
            .ENTRY_T (word_t),
            .DEPTH   (SET_NUM * BLOCK_WORDS),
            .LANES   (WORD_BYTES)
        ) i_data_ram (
            .clk      (clk),
            .rst_n    (rst_n),
            .addr0_i  (req_addr_i[TAG_LOW-1:WORD_LOW]),
            .en0_i    (!data_conflict),
            .rdata0_o (rdata0),
            .addr1_i  (commit_addr_i[TAG_LOW-1:WORD_LOW]),
            .we1_i    ({WORD_BYTES{commit_way_i[w]}} & commit_strb_i),
            .wdata1_i (commit_wdata_i),
            .rdata1_o (data_p1[w])
        );
    end

    // commit read-back, one cycle after the address
    assign commit_rdata_o       = commit_way_q[1] ? data_p1[1] : data_p1[0];
    assign commit_rdata_other_o = commit_way_q[1] ? data_p1[0] : data_p1[1];
    assign commit_miss_dirty_o  = commit_way_q[1] ? tag_p1[1].dirty : tag_p1[0].dirty;

    logic [WAY_NUM-1:0]    tag_hit;
    logic [WAY_NUM-1:0]    refill_way;
    cache_tag_t            victim_tag;
    word_t                 cache_word;
    word_t                 fwd_data;
    logic [WORD_BYTES-1:0] fwd_hit;
    logic [WORD_BYTES-1:0] m1_mask;
    logic                  m1_ale;
    logic                  m1_hit;
    word_t                 m1_merged;

    always_comb begin
        tag_hit    = '0;
        cache_word = '0;
        victim_tag = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            tag_hit[w] = tag_m1[w].valid & (tag_m1[w].tag == m1_addr[WORD_BITS-1:TAG_LOW]);
            if (tag_hit[w]) begin
                cache_word |= data_m1[w];
            end
            if (refill_way[w]) begin
                victim_tag = tag_m1[w];
            end
        end
    end

    // bytes touched by the load
    always_comb begin
        case (m1_msize)
            2'd0: m1_mask = WORD_BYTES'(1) << m1_addr[1:0];
            2'd1: m1_mask = m1_addr[1] ? 4'b1100 : 4'b0011;
            default: m1_mask = '1;
        endcase
    end

    always_comb begin
        case (m1_msize)
            2'd0: m1_ale = 1'b0;
            2'd1: m1_ale = m1_addr[0];
            default: m1_ale = |m1_addr[1:0];
        endcase
    end

    // store buffer bytes override the cache word
    always_comb begin
        for (int b = 0; b < WORD_BYTES; b++) begin
            m1_merged[8*b +: 8] = fwd_hit[b] ? fwd_data[8*b +: 8] : cache_word[8*b +: 8];
        end
    end

    assign m1_hit = (|tag_hit) | ((m1_mask & fwd_hit) == m1_mask);

    store_buffer i_store_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (m1_live & (|m1_strb) & !m1_ale),
        .push_addr_i  (m1_addr),
        .push_data_i  (m1_wdata),
        .push_strb_i  (m1_strb),
        .full_o       (sb_full),
        .fwd_addr_i   (m1_addr),
        .fwd_data_o   (fwd_data),
        .fwd_hit_o    (fwd_hit),
        .pop_i        (commit_fetch_sb_i),
        .head_valid_o (commit_sb_valid_o),
        .head_addr_o  (commit_sb_addr_o),
        .head_data_o  (commit_sb_data_o),
        .head_strb_o  (commit_sb_strb_o)
    );

    // victim pointer rotates on every miss
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            refill_way <= WAY_NUM'(1);
        end else if (m1_live && !m1_hit) begin
            refill_way <= {refill_way[WAY_NUM-2:0], refill_way[WAY_NUM-1]};
        end
    end

    logic                   m2_valid;
    word_t                  m2_word;
    logic [WORD_BITS-1:0]   m2_addr;
    logic [1:0]             m2_msize;
    logic                   m2_msigned;
    logic                   m2_ale;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m2_valid <= 1'b0;
        end else begin
            m2_valid <= m1_live;
        end
    end

    always_ff @(posedge clk) begin
        m2_word           <= m1_merged;
        m2_addr           <= m1_addr;
        m2_msize          <= m1_msize;
        m2_msigned        <= m1_msigned;
        m2_ale            <= m1_ale;
        resp_hit_o        <= m1_hit;
        resp_tag_hit_o    <= tag_hit;
        resp_refill_way_o <= refill_way;
        resp_dirty_o      <= victim_tag.dirty;
        resp_dirty_addr_o <= {victim_tag.tag, m1_addr[TAG_LOW-1:WORD_LOW], {WORD_LOW{1'b0}}};
        resp_wreg_id_o    <= m1_wreg_id;
    end

    load_align i_load_align (
        .addr_lo_i (m2_addr[1:0]),
        .msize_i   (m2_msize),
        .msigned_i (m2_msigned),
        .word_i    (m2_word),
        .data_o    (resp_rdata_o)
    );

    assign resp_valid_o = m2_valid;
    assign resp_exc_o   = m2_ale;
    assign resp_ecode_o = m2_ale ? ECODE_ALE : 6'd0;
    assign resp_badv_o  = m2_addr;

    commit_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(commit_way_i));

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int WAY_NUM = 2;
    localparam int SET_NUM = 16;
    localparam int BLOCK_WORDS = 4;

    // word and address layout
    localparam int WORD_BITS = 32;
    localparam int WORD_BYTES = WORD_BITS / 8;
    localparam int WORD_LOW = 2;
    localparam int INDEX_LOW = 4;
    localparam int TAG_LOW = 8;
    localparam int TAG_BITS = WORD_BITS - TAG_LOW;

    // store buffer entries
    localparam int SB_DEPTH = 4;

    // destination register id carried with a request
    localparam int REG_ID_BITS = 6;

    // misaligned access
    localparam logic [5:0] ECODE_ALE = 6'd9;

    typedef logic [WORD_BITS-1:0] word_t;

    // one tag entry per set and way
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } cache_tag_t;

endpackage

/* design/dpsram.sv */
`timescale 1ns/1ns

module dpsram #(
    parameter type ENTRY_T = logic [31:0],
    parameter int  DEPTH   = 16,
    parameter int  LANES   = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // read-only port
    input  logic [$clog2(DEPTH)-1:0] addr0_i,
    input  logic                     en0_i,
    output ENTRY_T                   rdata0_o,
    // read/write port
    input  logic [$clog2(DEPTH)-1:0] addr1_i,
    input  logic [LANES-1:0]         we1_i,
    input  ENTRY_T                   wdata1_i,
    output ENTRY_T                   rdata1_o
);
    localparam int ENTRY_W = $bits(ENTRY_T);
    localparam int LANE_W = ENTRY_W / LANES;

    ENTRY_T               mem [DEPTH];
    logic [ENTRY_W-1:0]   old_word;
    logic [ENTRY_W-1:0]   new_word;
    logic [ENTRY_W-1:0]   merged;

    // lane merge for port 1, also the write-first read value
    always_comb begin
        old_word = mem[addr1_i];
        new_word = wdata1_i;
        merged = old_word;
        for (int l = 0; l < LANES; l++) begin
            if (we1_i[l]) begin
                merged[l*LANE_W +: LANE_W] = new_word[l*LANE_W +: LANE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata0_o <= '0;
            rdata1_o <= '0;
        end else begin
            if (en0_i) begin
                rdata0_o <= mem[addr0_i];
            end
            if (|we1_i) begin
                mem[addr1_i] <= merged;
            end
            rdata1_o <= merged;
        end
    end

    addr0_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        en0_i |-> (int'(addr0_i) < DEPTH));

endmodule

/* design/load_align.sv */
`timescale 1ns/1ns

module load_align
    import dcache_pkg::*;
(
    input  logic [1:0] addr_lo_i,
    input  logic [1:0] msize_i,
    input  logic       msigned_i,
    input  word_t      word_i,
    output word_t      data_o
);
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (addr_lo_i)
            2'd0: byte_sel = word_i[7:0];
            2'd1: byte_sel = word_i[15:8];
            2'd2: byte_sel = word_i[23:16];
            default: byte_sel = word_i[31:24];
        endcase
    end

    // upper half when address bit 1 is set
    assign half_sel = addr_lo_i[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (msize_i)
            2'd0: data_o = {{(WORD_BITS-8){msigned_i & byte_sel[7]}}, byte_sel};
            2'd1: data_o = {{(WORD_BITS-16){msigned_i & half_sel[15]}}, half_sel};
            default: data_o = word_i;
        endcase
    end

endmodule

/* design/store_buffer.sv */
`timescale 1ns/1ns

module store_buffer
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // M1 store write
    input  logic                  push_i,
    input  logic [WORD_BITS-1:0]  push_addr_i,
    input  word_t                 push_data_i,
    input  logic [WORD_BYTES-1:0] push_strb_i,
    output logic                  full_o,
    // load forwarding
    input  logic [WORD_BITS-1:0]  fwd_addr_i,
    output word_t                 fwd_data_o,
    output logic [WORD_BYTES-1:0] fwd_hit_o,
    // commit drain
    input  logic                  pop_i,
    output logic                  head_valid_o,
    output logic [WORD_BITS-1:0]  head_addr_o,
    output word_t                 head_data_o,
    output logic [WORD_BYTES-1:0] head_strb_o
);
    localparam int PTR_W = $clog2(SB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [WORD_BITS-1:0]  addr_q [SB_DEPTH];
    word_t                 data_q [SB_DEPTH];
    logic [WORD_BYTES-1:0] strb_q [SB_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            addr_q[wr_ptr] <= push_addr_i;
            data_q[wr_ptr] <= push_data_i;
            strb_q[wr_ptr] <= push_strb_i;
        end
    end

    // also full when the store now in M1 takes the last slot
    assign full_o = (count == CNT_W'(SB_DEPTH))
                  | ((count == CNT_W'(SB_DEPTH - 1)) & push_i & !pop_i);

    assign head_valid_o = (count != '0);
    assign head_addr_o  = addr_q[rd_ptr];
    assign head_data_o  = data_q[rd_ptr];
    assign head_strb_o  = strb_q[rd_ptr];

    // walk oldest to youngest so the youngest byte wins
    always_comb begin
        logic [PTR_W-1:0] idx;
        fwd_data_o = '0;
        fwd_hit_o  = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            idx = rd_ptr + PTR_W'(i);
            if ((CNT_W'(i) < count) && (addr_q[idx][WORD_BITS-1:WORD_LOW] ==
                                        fwd_addr_i[WORD_BITS-1:WORD_LOW])) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (strb_q[idx][b]) begin
                        fwd_hit_o[b] = 1'b1;
                        fwd_data_o[8*b +: 8] = data_q[idx][8*b +: 8];
                    end
                end
            end
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> (count < CNT_W'(SB_DEPTH)));

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> (count != '0));

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_dcache -o sim_tb_dcache

./obj_dir/sim_tb_dcache 2>&1 | tee sim.log || true

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    exit 1
fi

/* testbench/tb_dcache.sv */
`timescale 1ns/1ns

module tb_dcache
    import dcache_pkg::*;
;
    localparam logic [2:0] K_CW    = 3'd0;
    localparam logic [2:0] K_CR    = 3'd1;
    localparam logic [2:0] K_REQ   = 3'd2;
    localparam logic [2:0] K_POP   = 3'd3;
    localparam logic [2:0] K_READY = 3'd4;

    // each row holds a commit action, a check or a request
    typedef struct packed {
        logic [2:0]  kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [1:0]  msize;
        logic        msigned;
        logic        wreg;
        logic [5:0]  wreg_id;
        logic        flush;
        logic        cw;
        logic [31:0] caddr;
        logic [31:0] cdata;
        logic [3:0]  cstrb;
        logic [1:0]  cway;
        logic        tag_we;
        cache_tag_t  tag;
        logic [31:0] exp_data;
        logic [31:0] exp_other;
        logic        exp_hit;
        logic [1:0]  exp_tag_hit;
        logic        exp_exc;
        logic        chk_data;
        logic        chk_victim;
        logic [1:0]  exp_way;
        logic        exp_dirty;
        logic [31:0] exp_daddr;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   flush_i;
    logic                   stall_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    logic [31:0]            req_addr_i;
    word_t                  req_wdata_i;
    logic [3:0]             req_strb_i;
    logic [1:0]             req_msize_i;
    logic                   req_msigned_i;
    logic                   req_wreg_i;
    logic [REG_ID_BITS-1:0] req_wreg_id_i;
    logic                   resp_ready_i;
    logic                   resp_valid_o;
    word_t                  resp_rdata_o;
    logic                   resp_hit_o;
    logic [1:0]             resp_tag_hit_o;
    logic                   resp_exc_o;
    logic [5:0]             resp_ecode_o;
    logic [31:0]            resp_badv_o;
    logic [1:0]             resp_refill_way_o;
    logic                   resp_dirty_o;
    logic [31:0]            resp_dirty_addr_o;
    logic [REG_ID_BITS-1:0] resp_wreg_id_o;
    logic                   wkup_valid_o;
    logic [REG_ID_BITS-1:0] wkup_reg_id_o;
    logic [31:0]            commit_addr_i;
    logic [1:0]             commit_way_i;
    logic                   commit_tag_we_i;
    cache_tag_t             commit_tag_i;
    logic [3:0]             commit_strb_i;
    word_t                  commit_wdata_i;
    logic                   commit_fetch_sb_i;
    word_t                  commit_rdata_o;
    word_t                  commit_rdata_other_o;
    logic                   commit_miss_dirty_o;
    logic                   commit_sb_valid_o;
    logic [31:0]            commit_sb_addr_o;
    word_t                  commit_sb_data_o;
    logic [3:0]             commit_sb_strb_o;

    row_t rows[$];
    int   cycles = 0;
    int   limit;

    dcache i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic add_commit(input logic [31:0] caddr, input logic [1:0] cway,
                              input logic tag_we, input cache_tag_t tag,
                              input logic [31:0] cdata);
        row_t r;
        r = '0;
        r.kind = K_CW;
        r.caddr = caddr;
        r.cway = cway;
        r.tag_we = tag_we;
        r.tag = tag;
        r.cstrb = 4'hf;
        r.cdata = cdata;
        rows.push_back(r);
    endtask

    task automatic add_cread(input logic [31:0] caddr, input logic [1:0] cway,
                             input logic [31:0] exp_data, input logic [31:0] exp_other,
                             input logic exp_dirty);
        row_t r;
        r = '0;
        r.kind = K_CR;
        r.caddr = caddr;
        r.cway = cway;
        r.exp_data = exp_data;
        r.exp_other = exp_other;
        r.exp_dirty = exp_dirty;
        rows.push_back(r);
    endtask

    task automatic add_req(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input logic [1:0] msize,
                           input logic msigned, input logic [31:0] exp_data,
                           input logic exp_hit, input logic [1:0] exp_tag_hit,
                           input logic exp_exc, input logic chk_data);
        row_t r;
        r = '0;
        r.kind = K_REQ;
        r.addr = addr;
        r.wdata = wdata;
        r.strb = strb;
        r.msize = msize;
        r.msigned = msigned;
        r.exp_data = exp_data;
        r.exp_hit = exp_hit;
        r.exp_tag_hit = exp_tag_hit;
        r.exp_exc = exp_exc;
        r.chk_data = chk_data;
        rows.push_back(r);
    endtask

    task automatic add_pop(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
        row_t r;
        r = '0;
        r.kind = K_POP;
        r.addr = addr;
        r.exp_data = data;
        r.strb = strb;
        rows.push_back(r);
    endtask

    task automatic add_ready(input logic exp);
        row_t r;
        r = '0;
        r.kind = K_READY;
        r.exp_hit = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // line with tag 0x000123 at index 2 goes into way 1
        add_commit(32'h0001_2320, 2'b10, 1'b1, {1'b1, 1'b1, 24'h000123}, 32'h80ff_7f01);
        add_commit(32'h0001_2324, 2'b10, 1'b0, '0, 32'h1122_3344);
        add_commit(32'h0001_2328, 2'b10, 1'b0, '0, 32'ha5a5_5a5a);
        add_commit(32'h0001_232c, 2'b10, 1'b0, '0, 32'hcafe_f00d);
        // way 0 holds a different word at the same index
        add_commit(32'h0001_2324, 2'b01, 1'b0, '0, 32'h5566_7788);
        add_cread(32'h0001_2324, 2'b10, 32'h1122_3344, 32'h5566_7788, 1'b1);
        add_req(32'h0001_2324, 0, 4'h0, 2'd2, 1'b0, 32'h1122_3344, 1'b1, 2'b10, 1'b0, 1'b1);
        rows[rows.size()-1].wreg = 1'b1;
        rows[rows.size()-1].wreg_id = 6'd5;
        // two misses walk the victim pointer from way 0 to way 1
        add_req(32'h0045_6320, 0, 4'h0, 2'd2, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b1);
        rows[rows.size()-1].chk_victim = 1'b1;
        rows[rows.size()-1].exp_way = 2'b01;
        rows[rows.size()-1].exp_dirty = 1'b0;
        rows[rows.size()-1].exp_daddr = 32'h0000_0020;
        add_req(32'h0078_9324, 0, 4'h0, 2'd2, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b1);
        rows[rows.size()-1].chk_victim = 1'b1;
        rows[rows.size()-1].exp_way = 2'b10;
        rows[rows.size()-1].exp_dirty = 1'b1;
        rows[rows.size()-1].exp_daddr = 32'h0001_2324;
        // byte and halfword selection on 0x80ff7f01
        add_req(32'h0001_2320, 0, 4'h0, 2'd0, 1'b1, 32'h0000_0001, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2321, 0, 4'h0, 2'd0, 1'b1, 32'h0000_007f, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2322, 0, 4'h0, 2'd0, 1'b1, 32'hffff_ffff, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2323, 0, 4'h0, 2'd0, 1'b0, 32'h0000_0080, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2323, 0, 4'h0, 2'd0, 1'b1, 32'hffff_ff80, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2320, 0, 4'h0, 2'd1, 1'b1, 32'h0000_7f01, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2322, 0, 4'h0, 2'd1, 1'b1, 32'hffff_80ff, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2322, 0, 4'h0, 2'd1, 1'b0, 32'h0000_80ff, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2321, 0, 4'h0, 2'd1, 1'b1, 32'h0, 1'b1, 2'b10, 1'b1, 1'b0);
        add_req(32'h0001_232a, 0, 4'h0, 2'd2, 1'b0, 32'h0, 1'b1, 2'b10, 1'b1, 1'b0);
        // store forwarding where the youngest store wins
        add_req(32'h0001_2325, 32'h0000_ab00, 4'h2, 2'd0, 1'b0, 32'h0, 1'b1, 2'b10, 1'b0, 1'b0);
        add_req(32'h0001_2324, 0, 4'h0, 2'd2, 1'b0, 32'h1122_ab44, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0001_2325, 32'h0000_cd00, 4'h2, 2'd0, 1'b0, 32'h0, 1'b1, 2'b10, 1'b0, 1'b0);
        add_req(32'h0001_2324, 0, 4'h0, 2'd2, 1'b0, 32'h1122_cd44, 1'b1, 2'b10, 1'b0, 1'b1);
        add_req(32'h0099_9340, 32'hdead_beef, 4'hf, 2'd2, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0);
        add_req(32'h0099_9342, 0, 4'h0, 2'd1, 1'b1, 32'hffff_dead, 1'b1, 2'b00, 1'b0, 1'b1);
        // drain oldest first
        add_pop(32'h0001_2325, 32'h0000_ab00, 4'h2);
        add_pop(32'h0001_2325, 32'h0000_cd00, 4'h2);
        add_pop(32'h0099_9340, 32'hdead_beef, 4'hf);
        // fill the store buffer
        add_req(32'h0001_2328, 32'h0000_0011, 4'h1, 2'd0, 1'b0, 32'h0, 1'b1, 2'b10, 1'b0, 1'b0);
        add_req(32'h0001_2329, 32'h0000_2200, 4'h2, 2'd0, 1'b0, 32'h0, 1'b1, 2'b10, 1'b0, 1'b0);
        add_req(32'h0001_232a, 32'h0033_0000, 4'h4, 2'd0, 1'b0, 32'h0, 1'b1, 2'b10, 1'b0, 1'b0);
        add_req(32'h0001_232b, 32'h4400_0000, 4'h8, 2'd0, 1'b0, 32'h0, 1'b1, 2'b10, 1'b0, 1'b0);
        add_ready(1'b0);
        add_pop(32'h0001_2328, 32'h0000_0011, 4'h1);
        add_ready(1'b1);
        add_pop(32'h0001_2329, 32'h0000_2200, 4'h2);
        add_pop(32'h0001_232a, 32'h0033_0000, 4'h4);
        add_pop(32'h0001_232b, 32'h4400_0000, 4'h8);
        // load racing a commit write to the same word
        add_req(32'h0001_232c, 0, 4'h0, 2'd2, 1'b0, 32'h600d_f00d, 1'b1, 2'b10, 1'b0, 1'b1);
        rows[rows.size()-1].cw = 1'b1;
        rows[rows.size()-1].caddr = 32'h0001_232c;
        rows[rows.size()-1].cway = 2'b10;
        rows[rows.size()-1].cstrb = 4'hf;
        rows[rows.size()-1].cdata = 32'h600d_f00d;
        // flushed load and store
        add_req(32'h0001_2324, 0, 4'h0, 2'd2, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0);
        rows[rows.size()-1].flush = 1'b1;
        rows[rows.size()-1].wreg = 1'b1;
        rows[rows.size()-1].wreg_id = 6'd7;
        add_req(32'h0001_2324, 32'h0000_00ee, 4'h1, 2'd0, 1'b0, 32'h0, 1'b0, 2'b00, 1'b0, 1'b0);
        rows[rows.size()-1].flush = 1'b1;
        add_req(32'h0001_2324, 0, 4'h0, 2'd2, 1'b0, 32'h1122_3344, 1'b1, 2'b10, 1'b0, 1'b1);
    endtask

    task automatic drive_commit(input row_t r);
        commit_addr_i   <= r.caddr;
        commit_way_i    <= r.cway;
        commit_tag_we_i <= r.tag_we;
        commit_tag_i    <= r.tag;
        commit_strb_i   <= r.cstrb;
        commit_wdata_i  <= r.cdata;
    endtask

    task automatic idle_commit();
        commit_way_i    <= 2'b00;
        commit_tag_we_i <= 1'b0;
        commit_strb_i   <= 4'h0;
    endtask

    task automatic apply_req(input row_t r, input int n);
        @(posedge clk);
        req_valid_i   <= 1'b1;
        req_addr_i    <= r.addr;
        req_wdata_i   <= r.wdata;
        req_strb_i    <= r.strb;
        req_msize_i   <= r.msize;
        req_msigned_i <= r.msigned;
        req_wreg_i    <= r.wreg;
        req_wreg_id_i <= r.wreg_id;
        if (r.cw) begin
            drive_commit(r);
        end
        @(negedge clk);
        while (!req_ready_o) begin
            @(negedge clk);
        end
        // acceptance edge
        @(posedge clk);
        req_valid_i <= 1'b0;
        idle_commit();
        if (r.flush) begin
            flush_i <= 1'b1;
        end
        @(negedge clk);
        check_value("wkup_valid_o", 32'(r.wreg & !r.flush), 32'(wkup_valid_o));
        if (r.wreg && !r.flush) begin
            check_value("wkup_reg_id_o", 32'(r.wreg_id), 32'(wkup_reg_id_o));
        end
        @(posedge clk);
        flush_i <= 1'b0;
        @(negedge clk);
        if (r.flush) begin
            check_value("resp_valid_o", 32'(0), 32'(resp_valid_o));
        end else begin
            if (!resp_valid_o) begin
                $display("no response pulse for request in table row %0d", n);
                $display("Testbench failed");
                $fatal(1);
            end
            check_value("resp_hit_o", 32'(r.exp_hit), 32'(resp_hit_o));
            check_value("resp_tag_hit_o", 32'(r.exp_tag_hit), 32'(resp_tag_hit_o));
            check_value("resp_exc_o", 32'(r.exp_exc), 32'(resp_exc_o));
            if (r.exp_exc) begin
                check_value("resp_ecode_o", 32'(ECODE_ALE), 32'(resp_ecode_o));
                check_value("resp_badv_o", r.addr, resp_badv_o);
            end else begin
                check_value("resp_ecode_o", 32'(0), 32'(resp_ecode_o));
            end
            if (r.chk_data) begin
                check_value("resp_rdata_o", r.exp_data, resp_rdata_o);
            end
            if (r.wreg) begin
                check_value("resp_wreg_id_o", 32'(r.wreg_id), 32'(resp_wreg_id_o));
            end
            if (r.chk_victim) begin
                check_value("resp_refill_way_o", 32'(r.exp_way), 32'(resp_refill_way_o));
                check_value("resp_dirty_o", 32'(r.exp_dirty), 32'(resp_dirty_o));
                check_value("resp_dirty_addr_o", r.exp_daddr, resp_dirty_addr_o);
            end
        end
    endtask

    task automatic apply_row(input row_t r, input int n);
        case (r.kind)
            K_CW: begin
                @(posedge clk);
                drive_commit(r);
                @(posedge clk);
                idle_commit();
            end
            K_CR: begin
                @(posedge clk);
                drive_commit(r);
                @(posedge clk);
                idle_commit();
                @(negedge clk);
                check_value("commit_rdata_o", r.exp_data, commit_rdata_o);
                check_value("commit_rdata_other_o", r.exp_other, commit_rdata_other_o);
                check_value("commit_miss_dirty_o", 32'(r.exp_dirty), 32'(commit_miss_dirty_o));
            end
            K_POP: begin
                @(negedge clk);
                check_value("commit_sb_valid_o", 32'(1), 32'(commit_sb_valid_o));
                check_value("commit_sb_addr_o", r.addr, commit_sb_addr_o);
                check_value("commit_sb_data_o", r.exp_data, commit_sb_data_o);
                check_value("commit_sb_strb_o", 32'(r.strb), 32'(commit_sb_strb_o));
                @(posedge clk);
                commit_fetch_sb_i <= 1'b1;
                @(posedge clk);
                commit_fetch_sb_i <= 1'b0;
            end
            K_READY: begin
                @(negedge clk);
                check_value("req_ready_o", 32'(r.exp_hit), 32'(req_ready_o));
            end
            default: begin
                apply_req(r, n);
            end
        endcase
    endtask

    initial begin
        limit             <= 0;
        rst_n             <= 1'b0;
        flush_i           <= 1'b0;
        stall_i           <= 1'b0;
        req_valid_i       <= 1'b0;
        req_addr_i        <= '0;
        req_wdata_i       <= '0;
        req_strb_i        <= '0;
        req_msize_i       <= '0;
        req_msigned_i     <= 1'b0;
        req_wreg_i        <= 1'b0;
        req_wreg_id_i     <= '0;
        resp_ready_i      <= 1'b1;
        commit_addr_i     <= '0;
        commit_way_i      <= '0;
        commit_tag_we_i   <= 1'b0;
        commit_tag_i      <= '0;
        commit_strb_i     <= '0;
        commit_wdata_i    <= '0;
        commit_fetch_sb_i <= 1'b0;
        build_table();
        limit <= rows.size() * 8 + 50;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("resp_valid_o", 32'(0), 32'(resp_valid_o));
        check_value("wkup_valid_o", 32'(0), 32'(wkup_valid_o));
        check_value("commit_sb_valid_o", 32'(0), 32'(commit_sb_valid_o));
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i], i);
        end
        // flushed store must not have reached the buffer
        @(negedge clk);
        check_value("commit_sb_valid_o", 32'(0), 32'(commit_sb_valid_o));
        $display("Testbench passed");
        $finish;
    end

endmodule
